/* src.f */
+incdir+include
source/angle_ctrl_pkg.sv
source/loop_timer.sv
source/angle_ctrl_fsm.sv
source/axis_mapper.sv
source/rate_limiter.sv
source/angle_ctrl_top.sv
verif/angle_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the angle controller testbench, result goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module angle_ctrl_tb \
	-o angle_ctrl_sim > sim.log 2>&1 \
	&& ./obj_dir/angle_ctrl_sim >> sim.log 2>&1 \
	|| echo "build or simulation stopped early" >> sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* verif/angle_ctrl_tb.sv */
`timescale 1ns/10ps

`include "angle_ctrl_cfg.svh"

module angle_ctrl_tb;

	typedef logic signed [`RATE_WIDTH-1:0] rate_val_t;
	typedef logic [`REC_VAL_WIDTH-1:0] stick_t;

	// every pass plus the three idle periods, with slack for reset and test gaps
	localparam int total_passes = 47;
	localparam int timeout_cycles = 10 + (total_passes + 3) * (`LOOP_PERIOD + 4) + 100;

	logic us_clk;
	logic resetn;
	logic arm;
	stick_t throttle_target;
	stick_t yaw_target;
	stick_t pitch_target;
	stick_t roll_target;
	rate_val_t pitch_actual;
	rate_val_t roll_actual;
	rate_val_t throttle_rate;
	rate_val_t yaw_rate;
	rate_val_t pitch_rate;
	rate_val_t roll_rate;
	rate_val_t pitch_angle_error;
	rate_val_t roll_angle_error;
	logic active;
	logic complete;
	logic check_outputs;

	rate_val_t exp_throttle;
	rate_val_t exp_yaw;
	rate_val_t exp_pitch;
	rate_val_t exp_roll;
	rate_val_t exp_pitch_err;
	rate_val_t exp_roll_err;

	logic [31:0] lfsr = 32'h1623;
	int cycle = 0;
	int gap = 0;
	int pass_count = 0;
	int errors = 0;
	int errors_at_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic fresh_arm = 1'b1;
	logic armed_once = 1'b0;
	logic [3:0] active_hist = '0;

	angle_ctrl_top DUT (
		.us_clk(us_clk),
		.resetn(resetn),
		.arm(arm),
		.throttle_target(throttle_target),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.pitch_actual(pitch_actual),
		.roll_actual(roll_actual),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.pitch_angle_error(pitch_angle_error),
		.roll_angle_error(roll_angle_error),
		.active(active),
		.complete(complete)
	);

	always #50 us_clk = ~us_clk;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < count; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	// stick 0..250 onto +-500 around centre
	function automatic int map_stick(input stick_t target);
		return int'(target) * 4 - `MAPPING_OFFSET;
	endfunction

	function automatic int scale_value(input int value, input int mult, input int shift);
		return (value * mult) >>> shift;
	endfunction

	function automatic rate_val_t clamp_value(input int value, input int lo, input int hi);
		if (value > hi) begin
			return rate_val_t'(hi);
		end else if (value < lo) begin
			return rate_val_t'(lo);
		end
		return rate_val_t'(value);
	endfunction

	task automatic report_mismatch(input string name, input int got, input int expected);
		errors++;
		$display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		if (got != expected) begin
			report_mismatch(name, got, expected);
		end
	endtask

	// new targets for the next pass, model result goes to the exp registers
	task automatic set_inputs(input stick_t thr, input stick_t yaw, input stick_t pitch,
		input stick_t roll, input rate_val_t p_act, input rate_val_t r_act);
		int mp;
		int mr;
		mp = map_stick(pitch) - int'(p_act);
		// imu roll sign is flipped
		mr = map_stick(roll) + int'(r_act);
		throttle_target <= thr;
		yaw_target <= yaw;
		pitch_target <= pitch;
		roll_target <= roll;
		pitch_actual <= p_act;
		roll_actual <= r_act;
		exp_throttle <= clamp_value(int'(thr) << `FIXED_POINT_SHIFT, `THROTTLE_MIN,
			`THROTTLE_MAX);
		exp_yaw <= clamp_value(scale_value(map_stick(yaw), `YAW_SCALE_MULT, `YAW_SCALE_DIV),
			`AXIS_RATE_MIN, `AXIS_RATE_MAX);
		exp_pitch <= clamp_value(scale_value(mp, `PITCH_SCALE_MULT, `PITCH_SCALE_DIV),
			`AXIS_RATE_MIN, `AXIS_RATE_MAX);
		exp_roll <= clamp_value(scale_value(mr, `ROLL_SCALE_MULT, `ROLL_SCALE_DIV),
			`AXIS_RATE_MIN, `AXIS_RATE_MAX);
		exp_pitch_err <= rate_val_t'(mp);
		exp_roll_err <= rate_val_t'(mr);
	endtask

	task automatic set_random_inputs();
		set_inputs(stick_t'(random_bits(8)), stick_t'(random_bits(8)),
			stick_t'(random_bits(8)), stick_t'(random_bits(8)),
			rate_val_t'(int'(random_bits(11)) - 1024),
			rate_val_t'(int'(random_bits(11)) - 1024));
	endtask

	// returns on the edge that samples complete high
	task automatic wait_complete();
		do begin
			@(posedge us_clk);
		end while (!complete);
	endtask

	// let the checks of this edge run, then report and resync
	task automatic finish_test(input string name);
		@(negedge us_clk);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
		@(posedge us_clk);
	endtask

	always @(posedge us_clk) begin
		cycle <= cycle + 1;
		if (cycle > timeout_cycles) begin
			$display("timeout: run did not end within %0d cycles", timeout_cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// pass spacing and active history for the timing checks
	always @(posedge us_clk) begin
		active_hist <= {active_hist[2:0], active};
		if (complete) begin
			gap <= 1;
			fresh_arm <= 1'b0;
			pass_count <= pass_count + 1;
		end else if (!arm) begin
			gap <= 0;
			fresh_arm <= 1'b1;
		end else begin
			gap <= gap + 1;
		end
	end

	// outputs hold their last pass while disarmed
	assign check_outputs = complete || (!arm && pass_count != 0);

	idle_before_arm: assert property (@(posedge us_clk)
		(cycle != 0 && !armed_once) |-> (!active && !complete && throttle_rate == '0
			&& yaw_rate == '0 && pitch_rate == '0 && roll_rate == '0
			&& pitch_angle_error == '0 && roll_angle_error == '0))
		else begin
			errors++;
			$display("at %0t ns the DUT was not idle during or after reset", $time);
		end

	complete_period: assert property (@(posedge us_clk)
		complete |-> gap == (fresh_arm ? `LOOP_PERIOD + 4 : `LOOP_PERIOD))
		else begin
			errors++;
			$display("at %0t ns complete came %0d cycles after the previous event",
				$time, $sampled(gap));
		end

	active_window: assert property (@(posedge us_clk)
		complete |-> (active_hist[2:0] == 3'b111 && !active_hist[3] && !active))
		else begin
			errors++;
			$display("at %0t ns active was not high for exactly three cycles", $time);
		end

	no_pass_disarmed: assert property (@(posedge us_clk) !arm |-> !complete)
		else begin
			errors++;
			$display("at %0t ns complete pulsed while arm was low", $time);
		end

	throttle_ok: assert property (@(posedge us_clk) check_outputs |-> throttle_rate == exp_throttle)
		else report_mismatch("throttle_rate", $sampled(throttle_rate), $sampled(exp_throttle));
	yaw_ok: assert property (@(posedge us_clk) check_outputs |-> yaw_rate == exp_yaw)
		else report_mismatch("yaw_rate", $sampled(yaw_rate), $sampled(exp_yaw));
	pitch_ok: assert property (@(posedge us_clk) check_outputs |-> pitch_rate == exp_pitch)
		else report_mismatch("pitch_rate", $sampled(pitch_rate), $sampled(exp_pitch));
	roll_ok: assert property (@(posedge us_clk) check_outputs |-> roll_rate == exp_roll)
		else report_mismatch("roll_rate", $sampled(roll_rate), $sampled(exp_roll));
	pitch_err_ok: assert property (@(posedge us_clk)
		check_outputs |-> pitch_angle_error == exp_pitch_err)
		else report_mismatch("pitch_angle_error", $sampled(pitch_angle_error),
			$sampled(exp_pitch_err));
	roll_err_ok: assert property (@(posedge us_clk)
		check_outputs |-> roll_angle_error == exp_roll_err)
		else report_mismatch("roll_angle_error", $sampled(roll_angle_error),
			$sampled(exp_roll_err));

	initial begin
		us_clk = 1'b0;
		resetn = 1'b0;
		arm = 1'b0;
		throttle_target = '0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		pitch_actual = '0;
		roll_actual = '0;
		repeat (10) @(posedge us_clk);
		resetn <= 1'b1;
		repeat (3) @(posedge us_clk);
		finish_test("reset");

		// centred sticks, also covers the loop timing
		set_inputs(8'd100, 8'd125, 8'd125, 8'd125, '0, '0);
		arm <= 1'b1;
		armed_once <= 1'b1;
		repeat (4) wait_complete();
		check_value("yaw_rate", yaw_rate, 0);
		check_value("throttle_rate", throttle_rate, 100 * 16);
		finish_test("centred sticks and loop timing");

		for (int i = 0; i < 40; i++) begin
			set_random_inputs();
			wait_complete();
		end
		finish_test("random passes");

		set_inputs(8'd255, 8'd0, 8'd0, 8'd255, 16'sd1024, 16'sd1024);
		wait_complete();
		check_value("pitch_rate", pitch_rate, -1600);
		check_value("roll_rate", roll_rate, 1600);
		check_value("throttle_rate", throttle_rate, 4000);
		set_inputs(8'd0, 8'd255, 8'd255, 8'd0, -16'sd1024, -16'sd1024);
		wait_complete();
		check_value("pitch_rate", pitch_rate, 1600);
		check_value("roll_rate", roll_rate, -1600);
		check_value("throttle_rate", throttle_rate, 0);
		finish_test("saturation");

		// new sticks while disarmed must not reach the outputs
		arm <= 1'b0;
		throttle_target <= stick_t'(random_bits(8));
		pitch_target <= stick_t'(random_bits(8));
		repeat (3 * `LOOP_PERIOD) @(posedge us_clk);
		set_random_inputs();
		arm <= 1'b1;
		wait_complete();
		finish_test("disarm and rearm");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* source/angle_ctrl_top.sv */
`timescale 1ns/10ps

module angle_ctrl_top (
	input  logic us_clk,
	input  logic resetn,
	input  logic arm,
	input  angle_ctrl_pkg::rec_val_t throttle_target,
	input  angle_ctrl_pkg::rec_val_t yaw_target,
	input  angle_ctrl_pkg::rec_val_t pitch_target,
	input  angle_ctrl_pkg::rec_val_t roll_target,
	input  angle_ctrl_pkg::rate_t pitch_actual,
	input  angle_ctrl_pkg::rate_t roll_actual,
	output angle_ctrl_pkg::rate_t throttle_rate,
	output angle_ctrl_pkg::rate_t yaw_rate,
	output angle_ctrl_pkg::rate_t pitch_rate,
	output angle_ctrl_pkg::rate_t roll_rate,
	output angle_ctrl_pkg::rate_t pitch_angle_error,
	output angle_ctrl_pkg::rate_t roll_angle_error,
	output logic active,
	output logic complete
);

	logic tick;
	logic map_load;
	logic scale_load;
	logic limit_load;

	// mapper to limiter
	angle_ctrl_pkg::ops_t mapped_throttle;
	angle_ctrl_pkg::ops_t mapped_yaw;
	angle_ctrl_pkg::ops_t mapped_pitch;
	angle_ctrl_pkg::ops_t mapped_roll;

	loop_timer u_loop_timer (
		.us_clk(us_clk),
		.resetn(resetn),
		.arm(arm),
		.tick(tick)
	);

	angle_ctrl_fsm u_angle_ctrl_fsm (
		.us_clk(us_clk),
		.resetn(resetn),
		.tick(tick),
		.map_load(map_load),
		.scale_load(scale_load),
		.limit_load(limit_load),
		.active(active),
		.complete(complete)
	);

	axis_mapper u_axis_mapper (
		.us_clk(us_clk),
		.resetn(resetn),
		.map_load(map_load),
		.throttle_target(throttle_target),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.pitch_actual(pitch_actual),
		.roll_actual(roll_actual),
		.mapped_throttle(mapped_throttle),
		.mapped_yaw(mapped_yaw),
		.mapped_pitch(mapped_pitch),
		.mapped_roll(mapped_roll),
		.pitch_angle_error(pitch_angle_error),
		.roll_angle_error(roll_angle_error)
	);

	rate_limiter u_rate_limiter (
		.us_clk(us_clk),
		.resetn(resetn),
		.scale_load(scale_load),
		.limit_load(limit_load),
		.mapped_throttle(mapped_throttle),
		.mapped_yaw(mapped_yaw),
		.mapped_pitch(mapped_pitch),
		.mapped_roll(mapped_roll),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate)
	);

endmodule

/* source/rate_limiter.sv */
`timescale 1ns/10ps

`include "angle_ctrl_cfg.svh"

module rate_limiter (
	input  logic us_clk,
	input  logic resetn,
	input  logic scale_load,
	input  logic limit_load,
	input  angle_ctrl_pkg::ops_t mapped_throttle,
	input  angle_ctrl_pkg::ops_t mapped_yaw,
	input  angle_ctrl_pkg::ops_t mapped_pitch,
	input  angle_ctrl_pkg::ops_t mapped_roll,
	output angle_ctrl_pkg::rate_t throttle_rate,
	output angle_ctrl_pkg::rate_t yaw_rate,
	output angle_ctrl_pkg::rate_t pitch_rate,
	output angle_ctrl_pkg::rate_t roll_rate
);

	import angle_ctrl_pkg::*;

	localparam ops_t throttle_max = ops_t'(`THROTTLE_MAX);
	localparam ops_t throttle_min = ops_t'(`THROTTLE_MIN);
	localparam ops_t axis_max = ops_t'(`AXIS_RATE_MAX);
	localparam ops_t axis_min = ops_t'(`AXIS_RATE_MIN);

	ops_t scaled_throttle;
	ops_t scaled_yaw;
	ops_t scaled_pitch;
	ops_t scaled_roll;

	// multiply then arithmetic shift, keeps the sign of the axis
	function automatic ops_t scale_axis(input ops_t value, input ops_t mult, input int div);
		return (value * mult) >>> div;
	endfunction

	function automatic rate_t clamp_axis(input ops_t value, input ops_t lo, input ops_t hi);
		rate_t result;
		if (value > hi) begin
			result = hi[`RATE_WIDTH-1:0];
		end else if (value < lo) begin
			result = lo[`RATE_WIDTH-1:0];
		end else begin
			result = value[`RATE_WIDTH-1:0];
		end
		return result;
	endfunction

	// scaled values, only read during limiting
	always_ff @(posedge us_clk) begin
		if (scale_load) begin
			scaled_throttle <= mapped_throttle;
			scaled_yaw <= scale_axis(mapped_yaw, ops_t'(`YAW_SCALE_MULT), `YAW_SCALE_DIV);
			scaled_pitch <= scale_axis(mapped_pitch, ops_t'(`PITCH_SCALE_MULT),
				`PITCH_SCALE_DIV);
			scaled_roll <= scale_axis(mapped_roll, ops_t'(`ROLL_SCALE_MULT), `ROLL_SCALE_DIV);
		end
	end

	// rate outputs hold between passes
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			throttle_rate <= '0;
			yaw_rate <= '0;
			pitch_rate <= '0;
			roll_rate <= '0;
		end else if (limit_load) begin
			throttle_rate <= clamp_axis(scaled_throttle, throttle_min, throttle_max);
			yaw_rate <= clamp_axis(scaled_yaw, axis_min, axis_max);
			pitch_rate <= clamp_axis(scaled_pitch, axis_min, axis_max);
			roll_rate <= clamp_axis(scaled_roll, axis_min, axis_max);
		end
	end

	rates_in_limits: assert property (
		@(posedge us_clk) disable iff (!resetn)
		limit_load |=> (throttle_rate >= throttle_min && throttle_rate <= throttle_max
			&& yaw_rate >= axis_min && yaw_rate <= axis_max
			&& pitch_rate >= axis_min && pitch_rate <= axis_max
			&& roll_rate >= axis_min && roll_rate <= axis_max)
	) else $error("rate_limiter: rate output outside its limits");

endmodule

/* source/axis_mapper.sv */
`timescale 1ns/10ps

`include "angle_ctrl_cfg.svh"

module axis_mapper (
	input  logic us_clk,
	input  logic resetn,
	input  logic map_load,
	input  angle_ctrl_pkg::rec_val_t throttle_target,
	input  angle_ctrl_pkg::rec_val_t yaw_target,
	input  angle_ctrl_pkg::rec_val_t pitch_target,
	input  angle_ctrl_pkg::rec_val_t roll_target,
	input  angle_ctrl_pkg::rate_t pitch_actual,
	input  angle_ctrl_pkg::rate_t roll_actual,
	output angle_ctrl_pkg::ops_t mapped_throttle,
	output angle_ctrl_pkg::ops_t mapped_yaw,
	output angle_ctrl_pkg::ops_t mapped_pitch,
	output angle_ctrl_pkg::ops_t mapped_roll,
	output angle_ctrl_pkg::rate_t pitch_angle_error,
	output angle_ctrl_pkg::rate_t roll_angle_error
);

	import angle_ctrl_pkg::*;

	// sticks span 0..250, times four gives +-500 around centre
	localparam int stick_shift = 2;
	localparam ops_t mapping_offset = ops_t'(`MAPPING_OFFSET);

	ops_t throttle_next;
	ops_t yaw_next;
	ops_t pitch_next;
	ops_t roll_next;

	always_comb begin
		throttle_next = ops_t'(throttle_target) <<< `FIXED_POINT_SHIFT;
		yaw_next = (ops_t'(yaw_target) <<< stick_shift) - mapping_offset;
		// imu roll sign is flipped, so add it
		roll_next = (ops_t'(roll_target) <<< stick_shift) - mapping_offset
			+ ops_t'(roll_actual);
		pitch_next = (ops_t'(pitch_target) <<< stick_shift) - mapping_offset
			- ops_t'(pitch_actual);
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			mapped_throttle <= '0;
			mapped_yaw <= '0;
			mapped_pitch <= '0;
			mapped_roll <= '0;
			pitch_angle_error <= '0;
			roll_angle_error <= '0;
		end else if (map_load) begin
			mapped_throttle <= throttle_next;
			mapped_yaw <= yaw_next;
			mapped_pitch <= pitch_next;
			mapped_roll <= roll_next;
			// error outputs are the 12.4 part of the mapped angles
			pitch_angle_error <= pitch_next[`RATE_WIDTH-1:0];
			roll_angle_error <= roll_next[`RATE_WIDTH-1:0];
		end
	end

endmodule

/* source/angle_ctrl_fsm.sv */
`timescale 1ns/10ps

module angle_ctrl_fsm (
	input  logic us_clk,
	input  logic resetn,
	input  logic tick,
	output logic map_load,
	output logic scale_load,
	output logic limit_load,
	output logic active,
	output logic complete
);

	import angle_ctrl_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state <= st_waiting;
		end else begin
			state <= next_state;
		end
	end

	// only waiting depends on an input
	always_comb begin
		case (state)
			st_waiting: begin
				if (tick) begin
					next_state = st_mapping;
				end else begin
					next_state = st_waiting;
				end
			end
			st_mapping: next_state = st_scaling;
			st_scaling: next_state = st_limiting;
			st_limiting: next_state = st_complete;
			st_complete: next_state = st_waiting;
			default: next_state = st_waiting;
		endcase
	end

	// one strobe per working state
	assign map_load = (state == st_mapping);
	assign scale_load = (state == st_scaling);
	assign limit_load = (state == st_limiting);

	assign active = map_load || scale_load || limit_load;
	assign complete = (state == st_complete);

	// loop period must cover a full pass
	tick_in_waiting: assert property (
		@(posedge us_clk) disable iff (!resetn)
		tick |-> (state == st_waiting)
	) else $error("angle_ctrl_fsm: tick arrived during a pass");

	strobes_exclusive: assert property (
		@(posedge us_clk) disable iff (!resetn)
		$onehot0({map_load, scale_load, limit_load})
	) else $error("angle_ctrl_fsm: more than one load strobe high");

endmodule

/* source/loop_timer.sv */
`timescale 1ns/10ps

`include "angle_ctrl_cfg.svh"

module loop_timer (
	input  logic us_clk,
	input  logic resetn,
	input  logic arm,
	output logic tick
);

	localparam int cnt_width = $clog2(`LOOP_PERIOD);
	localparam logic [cnt_width-1:0] last_count = cnt_width'(`LOOP_PERIOD - 1);

	logic [cnt_width-1:0] count;

	// counter only runs while armed
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			count <= '0;
			tick <= 1'b0;
		end else if (!arm) begin
			count <= '0;
			tick <= 1'b0;
		end else if (count == last_count) begin
			// wrap and fire, first tick lands a full period after arm
			count <= '0;
			tick <= 1'b1;
		end else begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

	// one pass per tick, so ticks never come back to back
	tick_single_cycle: assert property (
		@(posedge us_clk) disable iff (!resetn)
		tick |=> !tick
	) else $error("loop_timer: tick high for two cycles");

endmodule

/* source/angle_ctrl_pkg.sv */
`include "angle_ctrl_cfg.svh"

package angle_ctrl_pkg;

	// raw receiver stick value
	typedef logic [`REC_VAL_WIDTH-1:0] rec_val_t;

	// 12.4 angle or rate
	typedef logic signed [`RATE_WIDTH-1:0] rate_t;

	// wide signed intermediate for products
	typedef logic signed [`OPS_WIDTH-1:0] ops_t;

	// one control pass, then back to waiting
	typedef enum logic [2:0] {
		st_waiting,
		st_mapping,
		st_scaling,
		st_limiting,
		st_complete
	} ctrl_state_e;

endpackage

/* include/angle_ctrl_cfg.svh */
`ifndef ANGLE_CTRL_CFG_SVH
`define ANGLE_CTRL_CFG_SVH

// datapath widths
`define REC_VAL_WIDTH 8
`define RATE_WIDTH 16
`define OPS_WIDTH 32

// 12.4 fixed point
`define FIXED_POINT_SHIFT 4

// cycles between control-loop ticks, at least 5
`define LOOP_PERIOD 16

// stick centre of 125, shifted left by two
`define MAPPING_OFFSET 500

// per-axis multiplier and right shift
`define YAW_SCALE_MULT 48
`define YAW_SCALE_DIV 4
`define ROLL_SCALE_MULT 36
`define ROLL_SCALE_DIV 4
`define PITCH_SCALE_MULT 32
`define PITCH_SCALE_DIV 4

// output limits in 12.4
`define THROTTLE_MAX 4000
`define THROTTLE_MIN 0
`define AXIS_RATE_MAX 1600
`define AXIS_RATE_MIN (-1600)

`endif
